//--- Makefile
VERILATOR  ?= verilator
TOP        := cpu_tb
FILELIST   := lc3b_cpu.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- lc3b_cpu.f
source/lc3b_pkg.sv
source/regfile.sv
source/alu.sv
source/cc_branch.sv
source/cpu_datapath.sv
source/cpu_control.sv
source/cpu.sv
testbench/cpu_props.sv
testbench/cpu_tb.sv

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  lc3b_pkg::lc3b_aluop aluop,
    input  lc3b_pkg::lc3b_word  a,
    input  lc3b_pkg::lc3b_word  b,
    output lc3b_pkg::lc3b_word  f
);

    import lc3b_pkg::*;

    always_comb begin
        unique case (aluop)
            alu_add: begin
                f = a + b; // the carry out is dropped.
            end
            alu_and: begin
                f = a & b;
            end
            alu_not: begin
                f = ~a; // only the first operand matters here.
            end
            alu_pass: begin
                f = b;
            end
            default: begin
                f = b;
            end
        endcase
    end

endmodule : alu

//--- source/cc_branch.sv
`timescale 1ns/1ps

module cc_branch (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               load_cc,
    input  lc3b_pkg::lc3b_word result,
    input  logic [2:0]         nzp,
    output logic               branch_enable
);

    import lc3b_pkg::*;

    logic [2:0] cc; // bit 2 is n, bit 1 is z, bit 0 is p.
    logic [2:0] flags;
    logic       neg;
    logic       zero;

    assign neg   = result[15];
    assign zero  = (result == '0);
    assign flags = {neg, zero, !neg && !zero};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cc <= 3'b010; // the registers are zero out of reset.
        end else if (load_cc) begin
            cc <= flags;
        end
    end

    // exactly one flag is set, so any overlap with the mask takes the branch.
    assign branch_enable = |(nzp & cc);

endmodule : cc_branch

//--- source/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter lc3b_pkg::lc3b_word reset_vector = 16'h0000
) (
    input  logic               clk,
    input  logic               arst_n,
    input  lc3b_pkg::lc3b_word mem_rdata,
    input  logic               mem_resp,
    output lc3b_pkg::lc3b_word mem_address,
    output lc3b_pkg::lc3b_word mem_wdata,
    output logic               mem_read,
    output logic               mem_write
);

    import lc3b_pkg::*;

    // datapath to control.
    lc3b_opcode      opcode;
    logic            inst5;
    logic            branch_enable;

    // control to datapath.
    logic            load_pc;
    logic            load_ir;
    logic            load_regfile;
    logic            load_mar;
    logic            load_mdr;
    logic            load_cc;
    pcmux_sel_t      pcmux_sel;
    marmux_sel_t     marmux_sel;
    regfilemux_sel_t regfilemux_sel;
    alumux_sel_t     alumux_sel;
    logic            storemux_sel;
    logic            mdrmux_sel;
    lc3b_aluop       aluop;

    cpu_control _cpu_control (
        .clk,
        .arst_n,
        .opcode,
        .inst5,
        .branch_enable,
        .mem_resp,
        .load_pc,
        .load_ir,
        .load_regfile,
        .load_mar,
        .load_mdr,
        .load_cc,
        .pcmux_sel,
        .marmux_sel,
        .regfilemux_sel,
        .alumux_sel,
        .storemux_sel,
        .mdrmux_sel,
        .aluop,
        .mem_read,  // the strobes leave the chip as they are.
        .mem_write
    );

    cpu_datapath #(
        .reset_vector (reset_vector)
    ) _cpu_datapath (
        .clk,
        .arst_n,
        .load_pc,
        .load_ir,
        .load_regfile,
        .load_mar,
        .load_mdr,
        .load_cc,
        .pcmux_sel,
        .marmux_sel,
        .regfilemux_sel,
        .alumux_sel,
        .storemux_sel,
        .mdrmux_sel,
        .aluop,
        .mem_rdata,
        .mem_address,
        .mem_wdata,
        .opcode,
        .inst5,
        .branch_enable
    );

endmodule : cpu

//--- source/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic                          clk,
    input  logic                          arst_n,
    input  lc3b_pkg::lc3b_opcode          opcode,
    input  logic                          inst5,
    input  logic                          branch_enable,
    input  logic                          mem_resp,
    output logic                          load_pc,
    output logic                          load_ir,
    output logic                          load_regfile,
    output logic                          load_mar,
    output logic                          load_mdr,
    output logic                          load_cc,
    output lc3b_pkg::pcmux_sel_t          pcmux_sel,
    output lc3b_pkg::marmux_sel_t         marmux_sel,
    output lc3b_pkg::regfilemux_sel_t     regfilemux_sel,
    output lc3b_pkg::alumux_sel_t         alumux_sel,
    output logic                          storemux_sel,
    output logic                          mdrmux_sel,
    output lc3b_pkg::lc3b_aluop           aluop,
    output logic                          mem_read,
    output logic                          mem_write
);

    import lc3b_pkg::*;

    typedef enum logic [3:0] {
        s_fetch1, s_fetch2, s_fetch3, s_decode,
        s_add, s_and, s_not, s_lea, s_jmp, s_br,
        s_ldr1, s_ldr2, s_ldr3,
        s_str1, s_str2, s_str3
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_fetch1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = s_fetch1; // every execute state falls back to fetch.
        unique case (state)
            s_fetch1: next_state = s_fetch2;
            s_fetch2: next_state = mem_resp ? s_fetch3 : s_fetch2;
            s_fetch3: next_state = s_decode;
            s_decode: begin
                case (opcode)
                    op_add:  next_state = s_add;
                    op_and:  next_state = s_and;
                    op_not:  next_state = s_not;
                    op_lea:  next_state = s_lea;
                    op_jmp:  next_state = s_jmp;
                    op_br:   next_state = s_br;
                    op_ldr:  next_state = s_ldr1;
                    op_str:  next_state = s_str1;
                    default: next_state = s_fetch1; // unsupported, so a no-op.
                endcase
            end
            s_ldr1:   next_state = s_ldr2;
            s_ldr2:   next_state = mem_resp ? s_ldr3 : s_ldr2;
            s_str1:   next_state = s_str2;
            s_str2:   next_state = s_str3;
            s_str3:   next_state = mem_resp ? s_fetch1 : s_str3;
            default:  next_state = s_fetch1;
        endcase
    end

    always_comb begin
        load_pc        = 1'b0;
        load_ir        = 1'b0;
        load_regfile   = 1'b0;
        load_mar       = 1'b0;
        load_mdr       = 1'b0;
        load_cc        = 1'b0;
        pcmux_sel      = pc_plus2;
        marmux_sel     = mar_pc;
        regfilemux_sel = rf_alu;
        alumux_sel     = alu_sr2;
        storemux_sel   = 1'b0;
        mdrmux_sel     = 1'b0;
        aluop          = alu_pass;
        mem_read       = 1'b0;
        mem_write      = 1'b0;

        // the second alu operand of add and and follows the immediate bit.
        case (state)
            s_fetch1: load_mar = 1'b1;
            s_fetch2: begin
                mem_read = 1'b1;
                load_mdr = 1'b1; // the mdr holds rdata after the response edge.
            end
            s_fetch3: begin
                load_ir = 1'b1;
                load_pc = 1'b1;
            end
            s_add, s_and, s_not: begin
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                alumux_sel   = inst5 ? alu_imm5 : alu_sr2;
                if (state == s_add) begin
                    aluop = alu_add;
                end else if (state == s_and) begin
                    aluop = alu_and;
                end else begin
                    aluop = alu_not;
                end
            end
            s_lea: begin
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
                regfilemux_sel = rf_addr;
            end
            s_jmp: begin
                load_pc   = 1'b1;
                pcmux_sel = pc_reg;
            end
            s_br: begin
                load_pc   = branch_enable; // only a taken branch moves the pc.
                pcmux_sel = pc_target;
            end
            s_ldr1, s_str1: begin
                load_mar   = 1'b1;
                marmux_sel = mar_alu;
                alumux_sel = alu_off6;
                aluop      = alu_add;
            end
            s_ldr2: begin
                mem_read = 1'b1;
                load_mdr = 1'b1;
            end
            s_ldr3: begin
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
                regfilemux_sel = rf_mdr;
            end
            s_str2: begin
                storemux_sel = 1'b1; // read the source register on port a.
                mdrmux_sel   = 1'b1;
                load_mdr     = 1'b1;
            end
            s_str3:   mem_write = 1'b1;
            default:  ;
        endcase
    end

endmodule : cpu_control

//--- source/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath #(
    parameter lc3b_pkg::lc3b_word reset_vector = 16'h0000
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          load_pc,
    input  logic                          load_ir,
    input  logic                          load_regfile,
    input  logic                          load_mar,
    input  logic                          load_mdr,
    input  logic                          load_cc,
    input  lc3b_pkg::pcmux_sel_t          pcmux_sel,
    input  lc3b_pkg::marmux_sel_t         marmux_sel,
    input  lc3b_pkg::regfilemux_sel_t     regfilemux_sel,
    input  lc3b_pkg::alumux_sel_t         alumux_sel,
    input  logic                          storemux_sel,
    input  logic                          mdrmux_sel,
    input  lc3b_pkg::lc3b_aluop           aluop,
    input  lc3b_pkg::lc3b_word            mem_rdata,
    output lc3b_pkg::lc3b_word            mem_address,
    output lc3b_pkg::lc3b_word            mem_wdata,
    output lc3b_pkg::lc3b_opcode          opcode,
    output logic                          inst5,
    output logic                          branch_enable
);

    import lc3b_pkg::*;

    lc3b_word   pc;
    lc3b_word   ir;
    lc3b_word   mar;
    lc3b_word   mdr;
    lc3b_word   imm5_sext;
    lc3b_word   off6_sext;
    lc3b_word   off9_sext;
    lc3b_word   addr_sum;
    lc3b_word   pcmux_out;
    lc3b_word   marmux_out;
    lc3b_word   mdrmux_out;
    lc3b_word   regfilemux_out;
    lc3b_word   alumux_out;
    lc3b_word   alu_out;
    lc3b_word   reg_a;
    lc3b_word   reg_b;
    logic [2:0] src_a;

    // the first fetch after reset starts at the reset vector.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_vector;
        end else if (load_pc) begin
            pc <= pcmux_out;
        end
    end

    always_ff @(posedge clk) begin
        if (load_ir) ir <= mdr;
        if (load_mar) mar <= marmux_out;
        if (load_mdr) mdr <= mdrmux_out;
    end

    assign opcode = lc3b_opcode'(ir[15:12]);
    assign inst5  = ir[5];

    // word offsets are shifted left by one to become byte offsets.
    assign imm5_sext = {{11{ir[4]}}, ir[4:0]};
    assign off6_sext = {{9{ir[5]}}, ir[5:0], 1'b0};
    assign off9_sext = {{6{ir[8]}}, ir[8:0], 1'b0};

    assign addr_sum = pc + off9_sext; // pc already points past this instruction.

    assign src_a = storemux_sel ? ir[11:9] : ir[8:6];

    always_comb begin
        unique case (pcmux_sel)
            pc_target: pcmux_out = addr_sum;
            pc_reg:    pcmux_out = reg_a;
            default:   pcmux_out = pc + 16'd2;
        endcase
    end

    assign marmux_out = (marmux_sel == mar_alu) ? alu_out : pc;
    assign mdrmux_out = mdrmux_sel ? reg_a : mem_rdata; // store data or read data.

    always_comb begin
        unique case (alumux_sel)
            alu_imm5: alumux_out = imm5_sext;
            alu_off6: alumux_out = off6_sext;
            default:  alumux_out = reg_b;
        endcase
    end

    always_comb begin
        unique case (regfilemux_sel)
            rf_mdr:  regfilemux_out = mdr;
            rf_addr: regfilemux_out = addr_sum;
            default: regfilemux_out = alu_out;
        endcase
    end

    assign mem_address = mar;
    assign mem_wdata   = mdr;

    regfile _regfile (
        .clk,
        .arst_n,
        .load  (load_regfile),
        .src_a,
        .src_b (ir[2:0]),
        .dest  (ir[11:9]),
        .in    (regfilemux_out),
        .reg_a,
        .reg_b
    );

    alu _alu (
        .aluop,
        .a (reg_a),
        .b (alumux_out),
        .f (alu_out)
    );

    // flags follow whatever value is written to the register file.
    cc_branch _cc_branch (
        .clk,
        .arst_n,
        .load_cc,
        .result (regfilemux_out),
        .nzp    (ir[11:9]),
        .branch_enable
    );

endmodule : cpu_datapath

//--- source/lc3b_pkg.sv
package lc3b_pkg;

    // all data and addresses are one 16-bit word.
    typedef logic [15:0] lc3b_word;

    // the full opcode map is listed so that decode can spot the unsupported ones.
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_aluop;

    // next pc source.
    typedef enum logic [1:0] {pc_plus2, pc_target, pc_reg} pcmux_sel_t;

    typedef enum logic {mar_pc, mar_alu} marmux_sel_t;

    // register file write data source.
    typedef enum logic [1:0] {rf_alu, rf_mdr, rf_addr} regfilemux_sel_t;

    typedef enum logic [1:0] {alu_sr2, alu_imm5, alu_off6} alumux_sel_t;

endpackage : lc3b_pkg

//--- source/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               load,
    input  logic [2:0]         src_a,
    input  logic [2:0]         src_b,
    input  logic [2:0]         dest,
    input  lc3b_pkg::lc3b_word in,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b
);

    import lc3b_pkg::*;

    lc3b_word data [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // reads see the old value during a write cycle.
    assign reg_a = data[src_a];
    assign reg_b = data[src_b];

endmodule : regfile

//--- testbench/cpu_props.sv
`timescale 1ns/1ps

module cpu_props (
    input logic               clk,
    input logic               arst_n,
    input logic               mem_read,
    input logic               mem_write,
    input logic               mem_resp,
    input lc3b_pkg::lc3b_word mem_address,
    input lc3b_pkg::lc3b_word mem_wdata
);

    // the port carries one direction at a time.
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high in the same cycle");

    // a pending access may not change until the response edge.
    read_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_read && !mem_resp) |=> (mem_read && $stable(mem_address))
    ) else $error("read strobe or address changed before mem_resp");

    write_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_write && !mem_resp) |=>
            (mem_write && $stable(mem_address) && $stable(mem_wdata))
    ) else $error("write strobe, address or data changed before mem_resp");

    quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> (!mem_read && !mem_write)
    ) else $error("a memory strobe is high during reset");

endmodule : cpu_props

bind cpu cpu_props props (
    .clk,
    .arst_n,
    .mem_read,
    .mem_write,
    .mem_resp,
    .mem_address,
    .mem_wdata
);

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

    import lc3b_pkg::*;

    localparam lc3b_word reset_vector  = 16'h0010;
    localparam int       store_timeout = 400; // cycles allowed between two stores.

    logic     clk;
    logic     arst_n;
    lc3b_word mem_rdata;
    logic     mem_resp;
    lc3b_word mem_address;
    lc3b_word mem_wdata;
    logic     mem_read;
    logic     mem_write;

    lc3b_word image [256]; // memory contents at the start of the run.
    lc3b_word mem [256];
    lc3b_word exp_addr [$];
    lc3b_word exp_data [$];
    int       place_at;
    logic     busy;
    int       delay;

    cpu #(
        .reset_vector (reset_vector)
    ) DUT (
        .clk,
        .arst_n,
        .mem_rdata,
        .mem_resp,
        .mem_address,
        .mem_wdata,
        .mem_read,
        .mem_write
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic lc3b_word reg_form(input lc3b_opcode op, input int dr, input int sr1,
                                          input int sr2);
        return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction

    function automatic lc3b_word imm_form(input lc3b_opcode op, input int dr, input int sr1,
                                          input int imm);
        return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
    endfunction

    function automatic lc3b_word complement(input int dr, input int sr);
        return {op_not, 3'(dr), 3'(sr), 6'b111111};
    endfunction

    function automatic lc3b_word branch(input logic [2:0] nzp, input int off);
        return {op_br, nzp, 9'(off)}; // offset counts words from the next instruction.
    endfunction

    function automatic lc3b_word jump(input int base);
        return {op_jmp, 3'b000, 3'(base), 6'b000000};
    endfunction

    function automatic lc3b_word lea(input int dr, input int off);
        return {op_lea, 3'(dr), 9'(off)};
    endfunction

    function automatic lc3b_word mem_form(input lc3b_opcode op, input int r, input int base,
                                          input int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic void place(input lc3b_word w);
        image[place_at] = w;
        place_at++;
    endfunction

    // r6 points at the store area at 0x100, r5 into random data at 0x180.
    function automatic void load_program();
        place_at = int'(reset_vector[8:1]);
        place(lea(6, 119));
        place(mem_form(op_str, 6, 6, 0));   // stores the lea result itself.
        place(imm_form(op_add, 1, 0, 7));
        place(imm_form(op_add, 2, 1, -3));
        place(reg_form(op_add, 3, 1, 2));
        place(mem_form(op_str, 3, 6, 1));
        place(imm_form(op_and, 4, 3, 14));
        place(mem_form(op_str, 4, 6, 2));
        place(reg_form(op_and, 4, 3, 1));
        place(mem_form(op_str, 4, 6, 3));
        place(complement(5, 3));
        place(mem_form(op_str, 5, 6, 4));
        place(imm_form(op_add, 7, 5, 15));  // wraps around past 0xffff.
        place(mem_form(op_str, 7, 6, 5));
        place(imm_form(op_and, 7, 5, -8));
        place(mem_form(op_str, 7, 6, 6));
        place(lea(5, 167));
        place(mem_form(op_ldr, 1, 5, 3));
        place(mem_form(op_str, 1, 6, 7));
        place(mem_form(op_ldr, 2, 5, -2));
        place(mem_form(op_str, 2, 6, 8));
        place(reg_form(op_add, 3, 1, 2));
        place(mem_form(op_str, 3, 6, 9));
        place(mem_form(op_str, 1, 5, -5));  // copy to a computed address and read it back.
        place(mem_form(op_ldr, 4, 5, -5));
        place(mem_form(op_str, 4, 6, 10));
        // each flag gets one branch that falls through and one that skips a store.
        place(imm_form(op_add, 7, 0, -1));
        place(branch(3'b011, 1));
        place(mem_form(op_str, 7, 6, 11));
        place(branch(3'b100, 1));
        place(mem_form(op_str, 7, 6, 12));
        place(imm_form(op_and, 7, 7, 0));
        place(branch(3'b101, 1));
        place(mem_form(op_str, 7, 6, 12));
        place(branch(3'b010, 1));
        place(mem_form(op_str, 7, 6, 13));
        place(imm_form(op_add, 7, 7, 9));
        place(branch(3'b110, 1));
        place(mem_form(op_str, 7, 6, 13));
        place(branch(3'b001, 1));
        place(mem_form(op_str, 7, 6, 14));
        place(imm_form(op_add, 1, 0, 3));
        place(mem_form(op_str, 1, 6, 14));  // loop body runs three times.
        place(imm_form(op_add, 6, 6, 2));
        place(imm_form(op_add, 1, 1, -1));
        place(branch(3'b001, -4));
        place(lea(2, 2));
        place(jump(2));
        place(mem_form(op_str, 2, 6, 0));   // jumped over.
        place(mem_form(op_str, 2, 6, 15));
        place(branch(3'b111, 1));
        place(mem_form(op_str, 2, 6, 16));
        place(complement(3, 2));
        place(mem_form(op_str, 3, 6, 16));
        place(branch(3'b000, 1));           // an empty mask never branches.
        place(mem_form(op_str, 0, 6, 17));
        place(16'hf025);                    // trap is outside the subset.
        place(mem_form(op_str, 7, 6, 18));
        place(branch(3'b111, -1));
    endfunction

    // instruction-level model of the subset; it records every store in order.
    function automatic bit run_reference();
        lc3b_word   rmem [256];
        lc3b_word   r [8];
        lc3b_word   pc;
        lc3b_word   pc_next;
        lc3b_word   inst;
        lc3b_word   operand;
        lc3b_word   addr;
        lc3b_word   target;
        lc3b_word   res;
        logic [2:0] cc;
        bit         writes_reg;
        bit         reached_end;
        rmem = image;
        foreach (r[i]) r[i] = '0;
        pc = reset_vector;
        cc = 3'b010;
        reached_end = 1'b0;
        for (int step = 0; step < 5000 && !reached_end; step++) begin
            inst = rmem[pc[8:1]];
            pc_next = pc + 16'd2;
            writes_reg = 1'b0;
            res = '0;
            operand = inst[5] ? {{11{inst[4]}}, inst[4:0]} : r[inst[2:0]];
            addr = r[inst[8:6]] + {{9{inst[5]}}, inst[5:0], 1'b0};
            target = pc_next + {{6{inst[8]}}, inst[8:0], 1'b0};
            case (inst[15:12])
                op_add: begin
                    res = r[inst[8:6]] + operand;
                    writes_reg = 1'b1;
                end
                op_and: begin
                    res = r[inst[8:6]] & operand;
                    writes_reg = 1'b1;
                end
                op_not: begin
                    res = ~r[inst[8:6]];
                    writes_reg = 1'b1;
                end
                op_lea: begin
                    res = target;
                    writes_reg = 1'b1;
                end
                op_ldr: begin
                    res = rmem[addr[8:1]];
                    writes_reg = 1'b1;
                end
                op_str: begin
                    rmem[addr[8:1]] = r[inst[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[inst[11:9]]);
                end
                op_jmp: pc_next = r[inst[8:6]];
                op_br: begin
                    if ((inst[11:9] & cc) != 3'b000) begin
                        reached_end = (target == pc);
                        pc_next = target;
                    end
                end
                default: ;
            endcase
            if (writes_reg) begin
                r[inst[11:9]] = res;
                cc = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
            end
            pc = pc_next;
        end
        return reached_end;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string what, input lc3b_word got, input lc3b_word want);
        if (got !== want) begin
            stop_with_failure($sformatf("ERR %0t: %s is %h, expected %h",
                                        $time, what, got, want));
        end
    endtask

    task automatic wait_for_store(input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!(mem_resp && mem_write)) begin
            cycles++;
            if (cycles >= limit) begin
                stop_with_failure($sformatf("no store completed within %0d cycles", limit));
            end
            @(posedge clk);
        end
    endtask

    // memory answers each strobe once, 1 to 4 cycles after it first sees it.
    always @(negedge clk) begin
        if (mem_resp) begin
            mem_resp  = 1'b0;
            mem_rdata = 16'($urandom); // read data is only valid with mem_resp.
            busy      = 1'b0;
        end else if (mem_read || mem_write) begin
            if (!busy) begin
                busy  = 1'b1;
                delay = $urandom_range(3, 0);
            end
            if (delay == 0) begin
                if (mem_write) begin
                    mem[mem_address[8:1]] = mem_wdata;
                end else begin
                    mem_rdata = mem[mem_address[8:1]];
                end
                mem_resp = 1'b1;
            end else begin
                delay = delay - 1;
            end
        end
    end

    initial begin : setup_and_reset
        arst_n    = 1'b0;
        mem_resp  = 1'b0;
        mem_rdata = '0;
        busy      = 1'b0;
        delay     = 0;
        void'($urandom(32'h1c55_f9a9));
        foreach (image[i]) image[i] = 16'($urandom);
        load_program();
        mem = image;
        if (!run_reference()) begin
            stop_with_failure("the reference program never reached its final self branch");
        end
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
    end

    initial begin : compare_stores
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                stop_with_failure("reset was never released");
            end
        end
        foreach (exp_addr[i]) begin
            wait_for_store(store_timeout);
            check_equal("store address", mem_address, exp_addr[i]);
            check_equal("store data", mem_wdata, exp_data[i]);
        end
        // the program now spins on its last branch and must stay quiet.
        repeat (40) begin
            @(posedge clk);
            if (mem_resp && mem_write) begin
                stop_with_failure("a store completed after the last expected one");
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule : cpu_tb
